/* Bender.yml */
package:
  name: flowMux

sources:
  # Design sources in compile order
  - include_dirs:
      - include
    files:
      - design/flowMuxPkg.sv
      - design/flowFifo.sv
      - design/flowSelect.sv
      - design/flowMuxSelect.sv
      - design/flowPopReg.sv
      - design/flowMuxTop.sv

  # Testbench and bound assertions
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/flowMux_asserts.sv
      - bench/flowMuxTb.sv

/* bench/flowMuxTb.sv */
// ----------------------------------------------------------------------
// Flow mux testbench
// Drives the four producer flows and the consumer, checks every pop
// against per-flow reference queues
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "flowMux_cfg.svh"

module flowMuxTb;

  import flowMuxPkg::*;

  localparam int NumFlows = `FLOW_NUM_FLOWS;

  logic                      clk;
  logic                      rstN;
  selModeT                   mode;
  flowIdxT                   fixedSel;
  logic     [NumFlows-1:0]   pushValid;
  logic     [NumFlows-1:0]   pushReady;
  flowDataT [NumFlows-1:0]   pushData;
  logic                      popValid;
  logic                      popReady;
  flowDataT                  popData;

  // Stimulus control
  logic     [NumFlows-1:0]   pushEnable;
  bit                        pushRandom;
  bit                        popRandom;
  logic                      popLevel;
  logic     [5:0]            seqCnt [NumFlows];
  logic     [NumFlows-1:0]   fire;

  // Reference state and checker flags
  flowDataT                  refQ [NumFlows][$];
  int                        pushCount;
  int                        popCount;
  int                        acceptCount [NumFlows];
  bit                        fixedOnly;
  bit                        fairCheck;
  bit                        havePrev;
  flowIdxT                   prevFlow;
  bit                        prevStall;
  flowDataT                  prevData;

  flowMuxTop dut0 (
    .clk      (clk),
    .rstN     (rstN),
    .mode     (mode),
    .fixedSel (fixedSel),
    .pushValid(pushValid),
    .pushReady(pushReady),
    .pushData (pushData),
    .popValid (popValid),
    .popReady (popReady),
    .popData  (popData)
  );

  always #4 clk = ~clk;

  // ----------------------------------------------------------------------
  // Failure reporting and checks
  // ----------------------------------------------------------------------
  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp)
      abortRun($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // Expected item for a pop on flow f, taken from the head of its queue
  function automatic flowDataT expectedPop(input flowIdxT f);
    return refQ[f].pop_front();
  endfunction

  // ----------------------------------------------------------------------
  // Comparing process
  // ----------------------------------------------------------------------
  // Sampled at the falling edge, where all signals are settled
  always @(negedge clk)
  begin
    flowIdxT f;
    if (rstN)
    begin
      for (int i = 0; i < NumFlows; i++)
      begin
        if (pushValid[i] && pushReady[i])
        begin
          refQ[i].push_back(pushData[i]);
          pushCount++;
          acceptCount[i]++;
        end
      end
      // Stall at the last sample means nothing may have moved
      if (prevStall)
      begin
        checkValue("popValid", popValid, 1'b1);
        checkValue("popData", popData, prevData);
      end
      if (popValid && popReady)
      begin
        f = popData[`FLOW_WIDTH-1 -: $bits(flowIdxT)];
        if (refQ[f].size() == 0)
          abortRun($sformatf("Item popped on flow %0d with nothing pushed", f));
        checkValue("popData", popData, expectedPop(f));
        popCount++;
        if (fixedOnly)
          checkValue("popFlow", f, 2);
        if (fairCheck && havePrev)
          checkValue("popFlow", f, flowIdxT'(prevFlow + 1'b1));
        havePrev = fairCheck;
        prevFlow = f;
      end
      if (!fairCheck)
        havePrev = 1'b0;
      prevStall = popValid && !popReady;
      prevData  = popData;
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  // One clock of producer and consumer driving
  // A flow changes its item only once the current one is accepted
  task automatic stepCycle();
    @(negedge clk);
    fire = pushValid & pushReady;
    @(posedge clk);
    #1;
    for (int i = 0; i < NumFlows; i++)
    begin
      if (fire[i])
        seqCnt[i]++;
      if (!pushValid[i] || fire[i])
      begin
        pushValid[i] = pushEnable[i] && (pushRandom ? $urandom % 2 : 1'b1);
        pushData[i]  = {flowIdxT'(i), seqCnt[i]};
      end
    end
    popReady = popRandom ? 1'($urandom % 2) : popLevel;
  endtask

  task automatic runCycles(input int n);
    for (int i = 0; i < n; i++)
      stepCycle();
  endtask

  // Stop producers and run until the pop port stays quiet
  // Items still held by the design show up in the final counts
  task automatic waitIdle();
    int cycles;
    int quiet;
    pushEnable = '0;
    popRandom  = 1'b0;
    popLevel   = 1'b1;
    cycles     = 0;
    quiet      = 0;
    while (quiet < 2 * NumFlows)
    begin
      stepCycle();
      cycles++;
      if ((pushValid == '0) && !popValid)
        quiet++;
      else
        quiet = 0;
      if (cycles > 300)
        abortRun("Timeout waiting for the design to drain");
    end
  endtask

  initial
  begin
    int cycles;
    void'($urandom(32'h8fe8_9668));
    clk        = 1'b0;
    rstN       = 1'b0;
    mode       = SEL_ROUND_ROBIN;
    fixedSel   = '0;
    pushValid  = '0;
    pushData   = '0;
    popReady   = 1'b0;
    pushEnable = '0;
    pushRandom = 1'b0;
    popRandom  = 1'b0;
    popLevel   = 1'b0;
    fixedOnly  = 1'b0;
    fairCheck  = 1'b0;
    havePrev   = 1'b0;
    prevStall  = 1'b0;
    prevData   = '0;
    pushCount  = 0;
    popCount   = 0;
    for (int i = 0; i < NumFlows; i++)
    begin
      seqCnt[i]      = '0;
      acceptCount[i] = 0;
    end

    repeat (5) @(posedge clk);
    #1;
    rstN = 1'b1;

    // Reset state
    @(negedge clk);
    checkValue("popValid", popValid, 1'b0);
    checkValue("pushReady", pushReady, {NumFlows{1'b1}});

    // Random traffic in round robin
    pushEnable = '1;
    pushRandom = 1'b1;
    popRandom  = 1'b1;
    runCycles(400);
    waitIdle();

    // Fairness with every flow backlogged after a stalled fill
    pushRandom = 1'b0;
    pushEnable = '1;
    popLevel   = 1'b0;
    runCycles(20);
    popLevel   = 1'b1;
    runCycles(4);
    fairCheck  = 1'b1;
    runCycles(60);
    fairCheck  = 1'b0;
    waitIdle();

    // Fixed mode on flow 2 while the other flows fill and stall
    mode     = SEL_FIXED;
    fixedSel = flowIdxT'(2);
    runCycles(2);
    for (int i = 0; i < NumFlows; i++)
      acceptCount[i] = 0;
    fixedOnly  = 1'b1;
    pushEnable = '1;
    runCycles(40);
    for (int i = 0; i < NumFlows; i++)
    begin
      if (i != 2)
      begin
        checkValue($sformatf("acceptCount[%0d]", i), acceptCount[i], `FLOW_FIFO_DEPTH);
        checkValue($sformatf("pushReady[%0d]", i), pushReady[i], 1'b0);
      end
    end
    pushEnable = '0;
    runCycles(4);
    fixedOnly = 1'b0;
    mode      = SEL_ROUND_ROBIN;
    waitIdle();

    // Minimum latency on an idle design
    // Counted in edges from the cycle that presents the push
    mode     = SEL_FIXED;
    fixedSel = flowIdxT'(1);
    runCycles(3);
    checkValue("pushReady[1]", pushReady[1], 1'b1);
    cycles       = 0;
    pushValid[1] = 1'b1;
    pushData[1]  = {flowIdxT'(1), seqCnt[1]};
    @(posedge clk);
    #1;
    cycles++;
    pushValid[1] = 1'b0;
    seqCnt[1]++;
    while (!popValid)
    begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > 10)
        abortRun("Timeout waiting for the single item to reach popValid");
    end
    checkValue("latency", cycles, 2);
    mode = SEL_ROUND_ROBIN;
    waitIdle();

    // Nothing lost or duplicated
    checkValue("popCount", popCount, pushCount);
    for (int i = 0; i < NumFlows; i++)
      checkValue($sformatf("refQ[%0d].size", i), refQ[i].size(), 0);

    $display("Finished with no errors");
    $finish;
  end

endmodule : flowMuxTb

/* bench/flowMux_asserts.sv */
// ----------------------------------------------------------------------
// Flow mux assertions
// Handshake stability and select rules, bound into the top level
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "flowMux_cfg.svh"

module flowMuxAsserts (
  input logic                                 clk,
  input logic                                 rstN,
  input logic                                 popValid,
  input logic                                 popReady,
  input flowMuxPkg::flowDataT                 popData,
  input flowMuxPkg::flowIdxT                  sel,
  input logic                                 midValid,
  input logic                                 midReady,
  input logic [`FLOW_NUM_FLOWS-1:0]           headReady
);

  // Stalled pop port keeps valid and data
  popHold: assert property (@(posedge clk) disable iff (!rstN)
    popValid && !popReady |=> popValid && $stable(popData))
    else $error("popValid or popData changed under stall");

  // Select held while the mux output waits
  selHold: assert property (@(posedge clk) disable iff (!rstN)
    midValid && !midReady |=> $stable(sel))
    else $error("sel changed while midValid was stalled");

  // Ready goes back to one flow at most
  oneReady: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0(headReady))
    else $error("more than one headReady bit high");

  // Pop port empty out of reset
  resetEmpty: assert property (@(posedge clk)
    !rstN |=> !popValid)
    else $error("popValid high after reset");

endmodule : flowMuxAsserts

bind flowMuxTop flowMuxAsserts asserts0 (
  .clk      (clk),
  .rstN     (rstN),
  .popValid (popValid),
  .popReady (popReady),
  .popData  (popData),
  .sel      (sel),
  .midValid (midValid),
  .midReady (midReady),
  .headReady(headReady)
);

/* build.f */
+incdir+include
design/flowMuxPkg.sv
design/flowFifo.sv
design/flowSelect.sv
design/flowMuxSelect.sv
design/flowPopReg.sv
design/flowMuxTop.sv
bench/flowMux_asserts.sv
bench/flowMuxTb.sv

/* design/flowFifo.sv */
// ----------------------------------------------------------------------
// Flow FIFO
// Ready-valid buffer for one producer flow with a registered head
// One push and one pop per cycle, push stalls only when full
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module flowFifo #(
  // Must be at least 2
  parameter int Depth = 2
) (
  input  logic                 clk,
  input  logic                 rstN,

  input  logic                 pushValid,
  output logic                 pushReady,
  input  flowMuxPkg::flowDataT pushData,

  output logic                 headValid,
  input  logic                 headReady,
  output flowMuxPkg::flowDataT headData
);

  import flowMuxPkg::*;

  localparam int PtrW = $clog2(Depth);
  localparam int CntW = $clog2(Depth + 1);

  // Storage holds every entry, the head included
  flowDataT        mem [Depth];
  flowDataT        headQ;

  logic [PtrW-1:0] wrPtrQ;
  logic [PtrW-1:0] rdPtrQ;
  logic [PtrW-1:0] wrPtrNext;
  logic [PtrW-1:0] rdPtrNext;
  logic [CntW-1:0] countQ;

  logic            pushFire;
  logic            popFire;

  // ----------------------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------------------
  assign pushReady = (countQ != CntW'(Depth));
  assign headValid = (countQ != '0);
  assign headData  = headQ;

  assign pushFire  = pushValid && pushReady;
  assign popFire   = headValid && headReady;

  // Pointers wrap at Depth, which need not be a power of two
  assign wrPtrNext = (wrPtrQ == PtrW'(Depth - 1)) ? '0 : wrPtrQ + 1'b1;
  assign rdPtrNext = (rdPtrQ == PtrW'(Depth - 1)) ? '0 : rdPtrQ + 1'b1;

  // ----------------------------------------------------------------------
  // Storage and head register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (pushFire)
      mem[wrPtrQ] <= pushData;
  end

  // Head copy of mem[rdPtrQ]
  // Empty, or draining the last entry, takes the incoming item directly
  always_ff @(posedge clk)
  begin
    if (pushFire && ((countQ == '0) || (popFire && (countQ == CntW'(1)))))
      headQ <= pushData;
    else if (popFire && (countQ > CntW'(1)))
      headQ <= mem[rdPtrNext];
  end

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      wrPtrQ <= '0;
      rdPtrQ <= '0;
      countQ <= '0;
    end
    else
    begin
      if (pushFire)
        wrPtrQ <= wrPtrNext;
      if (popFire)
        rdPtrQ <= rdPtrNext;
      // Push and pop together leave the count alone
      if (pushFire && !popFire)
        countQ <= countQ + 1'b1;
      else if (popFire && !pushFire)
        countQ <= countQ - 1'b1;
    end
  end

endmodule : flowFifo

/* design/flowMuxPkg.sv */
// ----------------------------------------------------------------------
// Flow mux package
// Types shared by the flow FIFOs, the selector, the mux and the pop stage
// ----------------------------------------------------------------------

`include "flowMux_cfg.svh"

package flowMuxPkg;

  // Index of one producer flow
  typedef logic [$clog2(`FLOW_NUM_FLOWS)-1:0] flowIdxT;

  // One data item on any flow
  typedef logic [`FLOW_WIDTH-1:0] flowDataT;

  // ----------------------------------------------------------------------
  // Select mode opcodes
  // ----------------------------------------------------------------------
  // Round robin rotates over the flows with a valid head
  // Fixed takes the flow index from outside
  typedef enum logic
  {
    SEL_ROUND_ROBIN = 1'b0,
    SEL_FIXED       = 1'b1
  } selModeT;

endpackage : flowMuxPkg

/* design/flowMuxSelect.sv */
// ----------------------------------------------------------------------
// Flow mux with explicit select
// Steers valid and data of the selected flow forward
// and returns ready to that flow only, no clock and no state
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "flowMux_cfg.svh"

module flowMuxSelect (
  input  flowMuxPkg::flowIdxT                             sel,

  input  logic                 [`FLOW_NUM_FLOWS-1:0]      headValid,
  input  flowMuxPkg::flowDataT [`FLOW_NUM_FLOWS-1:0]      headData,
  output logic                 [`FLOW_NUM_FLOWS-1:0]      headReady,

  output logic                                            midValid,
  output flowMuxPkg::flowDataT                            midData,
  input  logic                                            midReady
);

  // ----------------------------------------------------------------------
  // Ready back to the chosen flow
  // ----------------------------------------------------------------------
  // Unselected flows always see ready low and stay stalled
  always_comb
  begin
    headReady      = '0;
    headReady[sel] = midReady;
  end

  // ----------------------------------------------------------------------
  // Valid and data forward
  // ----------------------------------------------------------------------
  // Stable as long as sel is held under back-pressure
  assign midValid = headValid[sel];
  assign midData  = headData[sel];

endmodule : flowMuxSelect

/* design/flowMuxTop.sv */
// ----------------------------------------------------------------------
// Flow mux top
// Merges the producer flows through per-flow FIFOs, a selector,
// the select mux and a registered pop stage onto one consumer port
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "flowMux_cfg.svh"

module flowMuxTop (
  input  logic                                        clk,
  input  logic                                        rstN,

  // Select control
  input  flowMuxPkg::selModeT                         mode,
  input  flowMuxPkg::flowIdxT                         fixedSel,

  // Producer side, one lane per flow
  input  logic                 [`FLOW_NUM_FLOWS-1:0]  pushValid,
  output logic                 [`FLOW_NUM_FLOWS-1:0]  pushReady,
  input  flowMuxPkg::flowDataT [`FLOW_NUM_FLOWS-1:0]  pushData,

  // Consumer side
  output logic                                        popValid,
  input  logic                                        popReady,
  output flowMuxPkg::flowDataT                        popData
);

  import flowMuxPkg::*;

  // FIFO heads toward the mux
  logic     [`FLOW_NUM_FLOWS-1:0] headValid;
  logic     [`FLOW_NUM_FLOWS-1:0] headReady;
  flowDataT [`FLOW_NUM_FLOWS-1:0] headData;

  // Mux output toward the pop stage
  flowIdxT  sel;
  logic     midValid;
  logic     midReady;
  flowDataT midData;

  // ----------------------------------------------------------------------
  // Per-flow FIFOs
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < `FLOW_NUM_FLOWS; i++)
  begin : genFifo
    flowFifo #(
      .Depth(`FLOW_FIFO_DEPTH)
    ) fifo (
      .clk      (clk),
      .rstN     (rstN),
      .pushValid(pushValid[i]),
      .pushReady(pushReady[i]),
      .pushData (pushData[i]),
      .headValid(headValid[i]),
      .headReady(headReady[i]),
      .headData (headData[i])
    );
  end

  // ----------------------------------------------------------------------
  // Selector, mux and pop stage
  // ----------------------------------------------------------------------
  flowSelect select0 (
    .clk      (clk),
    .rstN     (rstN),
    .mode     (mode),
    .fixedSel (fixedSel),
    .headValid(headValid),
    .midValid (midValid),
    .midReady (midReady),
    .sel      (sel)
  );

  flowMuxSelect mux0 (
    .sel      (sel),
    .headValid(headValid),
    .headData (headData),
    .headReady(headReady),
    .midValid (midValid),
    .midData  (midData),
    .midReady (midReady)
  );

  flowPopReg pop0 (
    .clk     (clk),
    .rstN    (rstN),
    .midValid(midValid),
    .midReady(midReady),
    .midData (midData),
    .popValid(popValid),
    .popReady(popReady),
    .popData (popData)
  );

endmodule : flowMuxTop

/* design/flowPopReg.sv */
// ----------------------------------------------------------------------
// Flow pop register
// One-entry pipeline stage in front of the consumer
// Full throughput, cuts the path from the FIFO heads to the pop port
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module flowPopReg (
  input  logic                 clk,
  input  logic                 rstN,

  input  logic                 midValid,
  output logic                 midReady,
  input  flowMuxPkg::flowDataT midData,

  output logic                 popValid,
  input  logic                 popReady,
  output flowMuxPkg::flowDataT popData
);

  import flowMuxPkg::*;

  logic     validQ;
  flowDataT dataQ;

  // Room when empty or when the held item leaves this cycle
  assign midReady = !validQ || popReady;

  assign popValid = validQ;
  assign popData  = dataQ;

  // ----------------------------------------------------------------------
  // Valid flag
  // ----------------------------------------------------------------------
  // Held while the consumer stalls a full register
  always_ff @(posedge clk)
  begin
    if (!rstN)
      validQ <= 1'b0;
    else if (midReady)
      validQ <= midValid;
  end

  // ----------------------------------------------------------------------
  // Data
  // ----------------------------------------------------------------------
  // Loaded only on a real transfer, so popData is stable under stall
  always_ff @(posedge clk)
  begin
    if (midValid && midReady)
      dataQ <= midData;
  end

endmodule : flowPopReg

/* design/flowSelect.sv */
// ----------------------------------------------------------------------
// Flow selector
// Picks the flow routed by the mux, round robin or fixed
// Holds its choice while the selected flow waits on the pop side
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "flowMux_cfg.svh"

module flowSelect (
  input  logic                        clk,
  input  logic                        rstN,

  input  flowMuxPkg::selModeT         mode,
  input  flowMuxPkg::flowIdxT         fixedSel,

  input  logic [`FLOW_NUM_FLOWS-1:0]  headValid,
  input  logic                        midValid,
  input  logic                        midReady,

  output flowMuxPkg::flowIdxT         sel
);

  import flowMuxPkg::*;

  flowIdxT selQ;
  flowIdxT nextRr;
  flowIdxT cand;
  logic    found;
  logic    locked;

  // Valid offered and not yet taken, so the choice must not move
  assign locked = midValid && !midReady;

  assign sel = selQ;

  // ----------------------------------------------------------------------
  // Round-robin search
  // ----------------------------------------------------------------------
  // Scan the flows after the current one in wrap-around order
  // The current flow itself is skipped, so a busy flow yields its turn
  // Nothing valid elsewhere keeps the current index
  always_comb
  begin
    nextRr = selQ;
    found  = 1'b0;
    cand   = selQ;
    for (int off = 1; off < `FLOW_NUM_FLOWS; off++)
    begin
      cand = flowIdxT'((int'(selQ) + off) % `FLOW_NUM_FLOWS);
      if (!found && headValid[cand])
      begin
        nextRr = cand;
        found  = 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Select register
  // ----------------------------------------------------------------------
  // Unlocked means either a transfer this cycle or an idle selected head
  always_ff @(posedge clk)
  begin
    if (!rstN)
      selQ <= '0;
    else if (!locked)
    begin
      case (mode)
        SEL_FIXED:
          selQ <= fixedSel;
        SEL_ROUND_ROBIN:
          selQ <= nextRr;
        default:
          selQ <= selQ;
      endcase
    end
  end

endmodule : flowSelect

/* include/flowMux_cfg.svh */
// ----------------------------------------------------------------------
// Flow mux configuration
// Sizes shared by the stream-merge subsystem and its testbench
// ----------------------------------------------------------------------

`ifndef FLOWMUX_CFG_SVH
`define FLOWMUX_CFG_SVH

// Number of producer flows merged onto the single consumer port
`define FLOW_NUM_FLOWS 4

// Data bits carried by one item
`define FLOW_WIDTH 8

// Entries buffered per producer flow
`define FLOW_FIFO_DEPTH 4

`endif
